/* design/pcie_trn_pkg.sv */
`default_nettype none

package pcie_trn_pkg;

    ////////////////////////////////////////
    // TRN receive stream, one beat per clock
    ////////////////////////////////////////
    typedef struct packed {
        logic [63:0] rd;                 // DW0 in the upper half
        logic [7:0]  rrem_n;             // byte remainder, active low
        logic        rsof_n;             // start of frame
        logic        reof_n;             // end of frame
        logic        rsrc_rdy_n;         // source has a beat
        logic        rsrc_dsc_n;         // source discontinue
        logic [6:0]  rbar_hit_n;         // one bit per BAR, active low
    } trn_rx_t;

    ////////////////////////////////////////
    // TLP header, first beat of a request
    ////////////////////////////////////////
    typedef struct packed {
        logic        rsvd0;              // DW0 bit 31
        logic [6:0]  fmt_type;           // fmt and type merged
        logic        rsvd1;
        logic [2:0]  tc;                 // traffic class
        logic [3:0]  rsvd2;
        logic        td;                 // digest present
        logic        ep;                 // poisoned
        logic [1:0]  attr;               // ordering and snoop
        logic [1:0]  rsvd3;
        logic [9:0]  length;             // payload in dwords
        logic [15:0] requester_id;       // DW1 starts here
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
    } tlp_hdr_t;

    // second beat of a 3DW request, address then data
    typedef struct packed {
        logic [31:0] addr_dw;            // DW2, dword address
        logic [31:0] data_dw;            // DW3, first payload dword
    } tlp_addr_data_t;

    // same 64 bits seen as header or as addr plus data
    typedef union packed {
        tlp_hdr_t       hdr;
        tlp_addr_data_t addr_data;
    } tlp_beat_u;

    ////////////////////////////////////////
    // request codes and BAR mapping
    ////////////////////////////////////////
    localparam logic [6:0] MEM_WR32_FMT_TYPE = 7'b10_00000;  // 3DW with data

    localparam int unsigned BAR_HUGE_PAGES = 2;  // host driver regs live in BAR2

endpackage

`default_nettype wire

/* design/huge_page_pkg.sv */
`default_nettype none

package huge_page_pkg;

    ////////////////////////////////////////
    // BAR2 register map, dword offsets
    ////////////////////////////////////////
    localparam logic [5:0] REG_PAGE1_ADDR   = 6'b100000;  // 0x80
    localparam logic [5:0] REG_PAGE2_ADDR   = 6'b100010;  // 0x88
    localparam logic [5:0] REG_PAGE1_UNLOCK = 6'b101000;  // 0xa0
    localparam logic [5:0] REG_PAGE2_UNLOCK = 6'b101001;  // 0xa4
    localparam logic [5:0] REG_COMPL_ADDR   = 6'b101100;  // 0xb0

    // one huge page as seen by the drain side
    typedef struct packed {
        logic [63:0] addr;               // host base address
        logic [31:0] qwords;             // page size in qwords
        logic        ready;              // handed over by the driver
    } page_desc_t;

    localparam int unsigned NUM_PAGES   = 2;  // ping-pong pair
    localparam int unsigned QWORD_BYTES = 8;  // addr step per qword
    localparam int unsigned DW_BYTES    = 4;
    localparam int unsigned BYTE_W      = 8;

    // parser states, one-hot
    localparam int unsigned         PARSE_ST_W = 5;
    localparam logic [PARSE_ST_W-1:0] ST_IDLE  = 5'b00001;
    localparam logic [PARSE_ST_W-1:0] ST_SEL   = 5'b00010;
    localparam logic [PARSE_ST_W-1:0] ST_ADDR1 = 5'b00100;
    localparam logic [PARSE_ST_W-1:0] ST_ADDR2 = 5'b01000;
    localparam logic [PARSE_ST_W-1:0] ST_COMPL = 5'b10000;

    // host payloads are little endian per dword
    function automatic logic [31:0] bswap32(input logic [31:0] dw);
        logic [31:0] sw;
        for (int i = 0; i < DW_BYTES; i++) begin
            sw[i*BYTE_W +: BYTE_W] = dw[(DW_BYTES-1-i)*BYTE_W +: BYTE_W];
        end
        return sw;
    endfunction

endpackage

`default_nettype wire

/* design/tx_huge_pages_addr.sv */
`default_nettype none
`timescale 1ns/1ps

module tx_huge_pages_addr (
    input  wire                         trn_clk,
    input  wire                         reset_n,
    input  wire pcie_trn_pkg::trn_rx_t  trn_rx,
    input  wire                         trn_rdst_rdy_n,
    input  wire                         free1,
    input  wire                         free2,
    output huge_page_pkg::page_desc_t   page1,
    output huge_page_pkg::page_desc_t   page2,
    output logic [63:0]                 completed_buffer_address
);

    import pcie_trn_pkg::*;
    import huge_page_pkg::*;

    tlp_beat_u                   beat;          // current rd, two views
    logic                        beat_ok;       // beat accepted this cycle
    logic                        wr_start;      // sof of a BAR2 32-bit write
    logic [5:0]                  reg_off;       // addr bits 7:2
    logic [63:0]                 beat_qword;    // swapped low dw plus high dw
    logic [PARSE_ST_W-1:0]       state;
    logic [31:0]                 aux_dw;        // first payload dword
    logic [NUM_PAGES-1:0]        unlock;        // one-cycle unlock pulses
    logic [NUM_PAGES-1:0]        free_vec;
    logic [NUM_PAGES-1:0]        page_ready;
    logic [NUM_PAGES-1:0][31:0]  page_qwords;
    logic [NUM_PAGES-1:0][63:0]  page_addr;

    assign beat     = trn_rx.rd;
    assign beat_ok  = !trn_rx.rsrc_rdy_n && !trn_rdst_rdy_n;
    assign reg_off  = beat.addr_data.addr_dw[7:2];
    assign free_vec = {free2, free1};

    assign wr_start = beat_ok && !trn_rx.rsof_n
                   && !trn_rx.rbar_hit_n[BAR_HUGE_PAGES]
                   && (beat.hdr.fmt_type == MEM_WR32_FMT_TYPE);

    // upper payload dw sits in the high half of the third beat
    assign beat_qword = {bswap32(beat.addr_data.addr_dw), bswap32(aux_dw)};

    ////////////////////////////////////////
    // request parser
    ////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state                    <= ST_IDLE;
            unlock                   <= '0;
            page_addr                <= '0;
            completed_buffer_address <= '0;
        end else begin
            unlock <= '0;                                   // pulse only
            case (state)
                ST_IDLE: begin
                    if (wr_start) begin
                        state <= ST_SEL;                    // wait for addr beat
                    end
                end
                ST_SEL: begin
                    if (beat_ok) begin
                        case (reg_off)
                            REG_PAGE1_ADDR:   state <= ST_ADDR1;
                            REG_PAGE2_ADDR:   state <= ST_ADDR2;
                            REG_PAGE1_UNLOCK: begin
                                unlock[0] <= 1'b1;          // size is in aux_dw
                                state     <= ST_IDLE;
                            end
                            REG_PAGE2_UNLOCK: begin
                                unlock[1] <= 1'b1;
                                state     <= ST_IDLE;
                            end
                            REG_COMPL_ADDR:   state <= ST_COMPL;
                            default:          state <= ST_IDLE;  // not ours
                        endcase
                    end
                end
                ST_ADDR1: begin
                    if (beat_ok) begin
                        page_addr[0] <= beat_qword;
                        state        <= ST_IDLE;
                    end
                end
                ST_ADDR2: begin
                    if (beat_ok) begin
                        page_addr[1] <= beat_qword;
                        state        <= ST_IDLE;
                    end
                end
                ST_COMPL: begin
                    if (beat_ok) begin
                        completed_buffer_address <= beat_qword;
                        state                    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;                  // illegal code
            endcase
        end
    end

    // low payload dword, held until the next beat or the unlock
    always_ff @(posedge trn_clk) begin
        if ((state == ST_SEL) && beat_ok) begin
            aux_dw <= beat.addr_data.data_dw;
        end
    end

    ////////////////////////////////////////
    // page status
    ////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            page_ready  <= '0;
            page_qwords <= '0;
        end else begin
            for (int p = 0; p < NUM_PAGES; p++) begin
                if (unlock[p]) begin                        // wins over free
                    page_ready[p]  <= 1'b1;
                    page_qwords[p] <= bswap32(aux_dw);
                end else if (free_vec[p]) begin
                    page_ready[p]  <= 1'b0;                 // drain is done
                end
            end
        end
    end

    assign page1 = '{addr: page_addr[0], qwords: page_qwords[0], ready: page_ready[0]};
    assign page2 = '{addr: page_addr[1], qwords: page_qwords[1], ready: page_ready[1]};

endmodule

`default_nettype wire

/* design/tx_page_drain.sv */
`default_nettype none
`timescale 1ns/1ps

module tx_page_drain (
    input  wire                         trn_clk,
    input  wire                         reset_n,
    input  wire huge_page_pkg::page_desc_t page1,
    input  wire huge_page_pkg::page_desc_t page2,
    input  wire                         tx_ready,
    output logic                        tx_qword_valid,
    output logic [63:0]                 tx_qword_addr,
    output logic                        free1,
    output logic                        free2
);

    import huge_page_pkg::*;

    logic        sel;            // 0 page1, 1 page2
    page_desc_t  cur_page;       // page under the selector
    logic [31:0] qw_left;        // qwords still to send
    logic        start;          // selected page picked up
    logic        empty_page;     // ready page with no qwords
    logic        xfer;           // valid and ready
    logic        last_xfer;      // final qword of the page
    logic        page_done;      // free the selected page

    assign cur_page   = sel ? page2 : page1;
    assign start      = !tx_qword_valid && cur_page.ready;
    assign empty_page = (cur_page.qwords == 32'd0);
    assign xfer       = tx_qword_valid && tx_ready;
    assign last_xfer  = xfer && (qw_left == 32'd1);
    assign page_done  = (start && empty_page) || last_xfer;

    ////////////////////////////////////////
    // ping-pong selector and free pulses
    ////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            sel   <= 1'b0;                       // page1 goes first
            free1 <= 1'b0;
            free2 <= 1'b0;
        end else begin
            free1 <= page_done && !sel;
            free2 <= page_done && sel;
            if (page_done) begin
                sel <= !sel;                     // strict alternation
            end
        end
    end

    ////////////////////////////////////////
    // qword address stream
    ////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_qword_valid <= 1'b0;
            tx_qword_addr  <= '0;
            qw_left        <= '0;
        end else begin
            if (start) begin
                tx_qword_addr  <= cur_page.addr;          // page base
                qw_left        <= cur_page.qwords;
                tx_qword_valid <= !empty_page;            // empty freed at once
            end else if (xfer) begin
                if (last_xfer) begin
                    tx_qword_valid <= 1'b0;
                end else begin
                    qw_left       <= qw_left - 32'd1;
                    tx_qword_addr <= tx_qword_addr + 64'(QWORD_BYTES);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/tx_dma_ctrl_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tx_dma_ctrl_top (
    input  wire                         trn_clk,
    input  wire                         reset_n,
    input  wire pcie_trn_pkg::trn_rx_t  trn_rx,
    input  wire                         trn_rdst_rdy_n,
    input  wire                         tx_ready,
    output wire                         tx_qword_valid,
    output wire [63:0]                  tx_qword_addr,
    output wire                         page1_status,
    output wire                         page2_status,
    output wire [63:0]                  page1_addr,
    output wire [63:0]                  page2_addr,
    output wire [63:0]                  completed_buffer_address
);

    import huge_page_pkg::*;

    page_desc_t page1;           // parser to drain
    page_desc_t page2;
    logic       free1;           // drain back to parser
    logic       free2;

    tx_huge_pages_addr u_parser (
        .trn_clk                  (trn_clk),
        .reset_n                  (reset_n),
        .trn_rx                   (trn_rx),
        .trn_rdst_rdy_n           (trn_rdst_rdy_n),
        .free1                    (free1),
        .free2                    (free2),
        .page1                    (page1),
        .page2                    (page2),
        .completed_buffer_address (completed_buffer_address)
    );

    tx_page_drain u_drain (
        .trn_clk        (trn_clk),
        .reset_n        (reset_n),
        .page1          (page1),
        .page2          (page2),
        .tx_ready       (tx_ready),
        .tx_qword_valid (tx_qword_valid),
        .tx_qword_addr  (tx_qword_addr),
        .free1          (free1),
        .free2          (free2)
    );

    assign page1_status = page1.ready;
    assign page2_status = page2.ready;
    assign page1_addr   = page1.addr;
    assign page2_addr   = page2.addr;

endmodule

`default_nettype wire

/* sim/tb_tx_dma_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_tx_dma_ctrl;

    import pcie_trn_pkg::*;

    logic        trn_clk;
    logic        reset_n;
    trn_rx_t     trn_rx;
    logic        trn_rdst_rdy_n;
    logic        tx_ready;
    wire         tx_qword_valid;
    wire [63:0]  tx_qword_addr;
    wire         page1_status;
    wire         page2_status;
    wire [63:0]  page1_addr;
    wire [63:0]  page2_addr;
    wire [63:0]  completed_buffer_address;

    string       lines[$];               // data lines, comments dropped
    int          wd_cycles = 0;          // watchdog budget, set after load
    logic        stall_en;               // random gaps on both TRN readies
    logic        bus_busy;               // accepted beat still on the bus
    int          next_page;              // ping-pong model, 1 or 2
    logic [63:0] exp_addr1;
    logic [63:0] exp_addr2;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    int          checks;

    tx_dma_ctrl_top DUT (
        .trn_clk                  (trn_clk),
        .reset_n                  (reset_n),
        .trn_rx                   (trn_rx),
        .trn_rdst_rdy_n           (trn_rdst_rdy_n),
        .tx_ready                 (tx_ready),
        .tx_qword_valid           (tx_qword_valid),
        .tx_qword_addr            (tx_qword_addr),
        .page1_status             (page1_status),
        .page2_status             (page2_status),
        .page1_addr               (page1_addr),
        .page2_addr               (page2_addr),
        .completed_buffer_address (completed_buffer_address)
    );

    always #2 trn_clk = ~trn_clk;        // 4 ns period

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic logic [31:0] swap_dw(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};   // host dwords are little endian
    endfunction

    // wire dwords in arrival order, low dword first
    function automatic logic [63:0] host_qword(input logic [31:0] lo_w, input logic [31:0] hi_w);
        return {swap_dw(hi_w), swap_dw(lo_w)};
    endfunction

    function automatic logic status_of(input int pg);
        return (pg == 1) ? page1_status : page2_status;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %0s", $time, msg);
        test_errs++;
        total_errs++;
    endtask

    task automatic check_qword(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%0s is %h, expected %h", what, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // TRN receive driver
    ////////////////////////////////////////
    task automatic send_beat(input logic [63:0] rd, input logic sof_n, input logic eof_n,
                             input logic [6:0] bar_n);
        logic taken;
        taken = 1'b0;
        while (!taken) begin                             // hold beat until accepted
            @(negedge trn_clk);
            trn_rx.rd         = rd;
            trn_rx.rsof_n     = sof_n;
            trn_rx.reof_n     = eof_n;
            trn_rx.rbar_hit_n = bar_n;
            trn_rx.rsrc_rdy_n = stall_en && ($urandom % 4 == 0);
            trn_rdst_rdy_n    = stall_en && ($urandom % 4 == 0);
            taken             = !trn_rx.rsrc_rdy_n && !trn_rdst_rdy_n;
        end
        bus_busy = 1'b1;                                 // taken at the next rising edge
    endtask

    // let the last beat go in, then park the bus
    task automatic settle_bus();
        if (bus_busy) begin
            @(negedge trn_clk);
            trn_rx.rsrc_rdy_n = 1'b1;
            trn_rx.rsof_n     = 1'b1;
            trn_rx.reof_n     = 1'b1;
            trn_rdst_rdy_n    = 1'b0;
            bus_busy          = 1'b0;
        end
    endtask

    // unlock register one cycle, status the next
    task automatic check_ready(input int pg);
        settle_bus();
        checks++;
        if (status_of(pg) !== 1'b0) begin
            report_error($sformatf("page%0d status rose one cycle early", pg));
        end
        @(negedge trn_clk);
        checks++;
        if (status_of(pg) !== 1'b1) begin
            report_error($sformatf("page%0d status low two cycles after unlock", pg));
        end
    endtask

    ////////////////////////////////////////
    // drain stream monitor
    ////////////////////////////////////////
    task automatic check_drain(input int unsigned count);
        int          pg;
        logic [63:0] base;
        int unsigned seen;
        pg   = next_page;                                // strict ping-pong
        base = (pg == 1) ? exp_addr1 : exp_addr2;
        seen = 0;
        settle_bus();
        if (count == 0) begin
            @(negedge trn_clk);                          // empty page freed at once
        end
        while (seen < count) begin
            tx_ready = ($urandom % 2 == 0);
            if (tx_qword_valid && tx_ready) begin        // transfer at the next edge
                check_qword($sformatf("page%0d qword %0d addr", pg, seen), tx_qword_addr,
                            base + 64'(8 * seen));
                seen++;
            end
            @(negedge trn_clk);
        end
        tx_ready = 1'b0;
        checks++;
        if (tx_qword_valid !== 1'b0 || status_of(pg) !== 1'b1) begin
            report_error($sformatf("page%0d stream or status wrong in its free cycle", pg));
        end
        @(negedge trn_clk);
        checks++;
        if (status_of(pg) !== 1'b0) begin
            report_error($sformatf("page%0d status still high after free", pg));
        end
        next_page = 3 - pg;
    endtask

    ////////////////////////////////////////
    // data file
    ////////////////////////////////////////
    task automatic load_data(output logic ok);
        int    fd;
        int    cnt;
        int    qw_sum;
        string line;
        string kw;
        qw_sum = 0;
        fd     = $fopen("sim/tx_dma_testdata.txt", "r");
        ok     = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                    if ($sscanf(line, "%s %d", kw, cnt) == 2 && kw == "drain") begin
                        qw_sum += cnt;                   // expected qwords for the budget
                    end
                end
            end
            $fclose(fd);
            wd_cycles = 50 * lines.size() + 4 * qw_sum;
        end
    endtask

    task automatic run_lines();
        string       kw;
        string       name;
        logic [63:0] v0;
        logic [63:0] v1;
        logic [63:0] v2;
        logic [63:0] v3;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %h %h %h %h", kw, v0, v1, v2, v3));
            if (kw == "test") begin
                void'($sscanf(lines[i], "%s %s", kw, name));
                test_name = name;
                test_errs = 0;
                tests_run++;
            end else if (kw == "stall") begin
                stall_en = v0[0];
            end else if (kw == "beat") begin
                send_beat(v0, v1[0], v2[0], v3[6:0]);
            end else if (kw == "page1") begin
                settle_bus();
                exp_addr1 = host_qword(v0[31:0], v1[31:0]);
                check_qword("page1_addr", page1_addr, exp_addr1);
            end else if (kw == "page2") begin
                settle_bus();
                exp_addr2 = host_qword(v0[31:0], v1[31:0]);
                check_qword("page2_addr", page2_addr, exp_addr2);
            end else if (kw == "compl") begin
                settle_bus();
                check_qword("completed_buffer_address", completed_buffer_address,
                            host_qword(v0[31:0], v1[31:0]));
            end else if (kw == "ready") begin
                check_ready((v0 == 64'd1) ? 1 : 2);
            end else if (kw == "drain") begin
                check_drain(v0[31:0]);
            end else if (kw == "end") begin
                settle_bus();
                $display("test %0s: %0s, %0d errors", test_name,
                         (test_errs == 0) ? "ok" : "failed", test_errs);
                if (test_errs != 0) begin
                    tests_failed++;
                end
            end else begin
                $display("data line not understood: %0s", lines[i]);
                total_errs++;
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        logic ok;
        trn_clk           = 1'b0;
        reset_n           = 1'b0;
        trn_rx            = '0;
        trn_rx.rsof_n     = 1'b1;
        trn_rx.reof_n     = 1'b1;
        trn_rx.rsrc_rdy_n = 1'b1;
        trn_rx.rsrc_dsc_n = 1'b1;
        trn_rx.rbar_hit_n = 7'h7f;
        trn_rdst_rdy_n    = 1'b0;
        tx_ready          = 1'b0;
        stall_en          = 1'b0;
        bus_busy          = 1'b0;
        next_page         = 1;                       // drain starts on page 1
        exp_addr1         = '0;
        exp_addr2         = '0;
        test_errs         = 0;
        total_errs        = 0;
        tests_run         = 0;
        tests_failed      = 0;
        checks            = 0;
        void'($urandom(25976));
        load_data(ok);
        if (!ok) begin
            $display("data file sim/tx_dma_testdata.txt could not be opened");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge trn_clk);
            @(negedge trn_clk);
            reset_n = 1'b1;
            run_lines();
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, total_errs);
            if (tests_failed == 0 && total_errs == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // watchdog, armed once the data file is in
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge trn_clk);
        $display("run timed out after %0d cycles", wd_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tx_dma_testdata.txt */
# beat  <rd hex> <rsof_n> <reof_n> <rbar_hit_n hex> | stall <0/1> | ready <page> | drain <qwords>
# page1/page2/compl <low wire dword> <high wire dword>, host order is byte swapped per dword
# test <name> opens a test, end closes it
test page_addr_no_stall
stall 0
beat 40000002000100FF 0 1 7B
beat F7C0008000604523 1 1 7B
beat 0100000000000000 1 0 7B
page1 00604523 01000000
beat 40000002000101FF 0 1 7B
beat F7C0008800000080 1 1 7B
beat 0200000000000000 1 0 7B
page2 00000080 02000000
end
test page_addr_stall
stall 1
beat 40000002000102FF 0 1 7B
beat F7C0008000100000 1 1 7B
beat 0300000000000000 1 0 7B
page1 00100000 03000000
end
test compl_addr
beat 40000002000104FF 0 1 7B
beat F7C000B040000000 1 1 7B
beat 0500000000000000 1 0 7B
compl 40000000 05000000
page1 00100000 03000000
page2 00000080 02000000
end
test ignored_writes
beat 40000002000105FF 0 1 7E
beat F7C00080EFBEADDE 1 1 7E
beat 1111111100000000 1 0 7E
beat 000000010001060F 0 1 7B
beat F7C0008800000000 1 0 7B
beat 400000010001070F 0 1 7B
beat F7C00040EFBEADDE 1 0 7B
page1 00100000 03000000
page2 00000080 02000000
compl 40000000 05000000
beat 40000002000108FF 0 1 7B
beat F7C0008000200000 1 1 7B
beat 0600000000000000 1 0 7B
page1 00200000 06000000
end
test unlock_drain
beat 400000010001090F 0 1 7B
beat F7C000A005000000 1 0 7B
ready 1
drain 5
beat 4000000100010A0F 0 1 7B
beat F7C000A403000000 1 0 7B
ready 2
drain 3
end
test ping_pong_order
beat 4000000100010B0F 0 1 7B
beat F7C000A406000000 1 0 7B
ready 2
beat 4000000100010C0F 0 1 7B
beat F7C000A004000000 1 0 7B
ready 1
drain 4
drain 6
end
test zero_page
beat 4000000100010D0F 0 1 7B
beat F7C000A000000000 1 0 7B
ready 1
drain 0
beat 4000000100010E0F 0 1 7B
beat F7C000A402000000 1 0 7B
ready 2
drain 2
end

/* tx_dma_ctrl_top.f */
design/pcie_trn_pkg.sv
design/huge_page_pkg.sv
design/tx_huge_pages_addr.sv
design/tx_page_drain.sv
design/tx_dma_ctrl_top.sv
sim/tb_tx_dma_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tx_dma_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_tx_dma_ctrl \
    -f tx_dma_ctrl_top.f -Mdir obj_dir -o tb_tx_dma_ctrl

out=$(./obj_dir/tb_tx_dma_ctrl)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
